// ==== hdl/tisConsts.svh ====
/* TPM TIS register map constants
   Register offsets, field bit positions and identity values */
`ifndef TIS_CONSTS_SVH
`define TIS_CONSTS_SVH

`define TIS_NUM_LOCALITIES 5
`define TIS_LOCALITY_NONE 4'hF

// Offsets inside one locality, always dword aligned
`define TIS_REG_ACCESS 12'h000
`define TIS_REG_INT_ENABLE 12'h008
`define TIS_REG_INT_VECTOR 12'h00C
`define TIS_REG_INT_STATUS 12'h010
`define TIS_REG_INTF_CAP 12'h014
`define TIS_REG_STS 12'h018
`define TIS_REG_DATA_FIFO 12'h024
`define TIS_REG_INTERFACE_ID 12'h030
`define TIS_REG_DID_VID 12'hF00
`define TIS_REG_RID 12'hF04

`define TIS_ACC_REQUEST_USE 1
`define TIS_ACC_SEIZE 3
`define TIS_ACC_BEEN_SEIZED 4
`define TIS_ACC_ACTIVE 5

`define TIS_STS_RETRY 1
`define TIS_STS_GO 5
`define TIS_STS_CMD_READY 6

`define TIS_INT_DATA_AVAIL 0
`define TIS_INT_LOC_CHANGE 2
`define TIS_INT_GLOBAL 7

// Identity words, byte 0 in the low bits
`define TIS_DID_VID 32'h0001_1B4E
`define TIS_RID 32'h0000_0000
`define TIS_INTERFACE_ID 32'h0000_2100 // FIFO interface, TIS only, 5 localities
`define TIS_INTF_CAP 32'h3000_0115 // Version 1.3, legacy transfer size

`define TIS_CMD_HDR_LEN 6
`define TIS_RAM_ADDR_W 11

`endif

// ==== hdl/tisPkg.sv ====
/* TPM TIS register file types
   Shared vectors, command FSM states and bundled buses */
`default_nettype none
`include "tisConsts.svh"

package tisPkg;

  typedef logic [7:0] byte_t;
  typedef logic [3:0] locality_t;
  typedef logic [11:0] regOffset_t;
  typedef logic [`TIS_RAM_ADDR_W-1:0] ramAddr_t;
  typedef logic [31:0] fifoCount_t; // Bytes left after the header
  typedef logic [`TIS_NUM_LOCALITIES-1:0] localityMask_t;

  // Low three bits index the byte inside reception and completion
  typedef enum logic [4:0] {
    stIdle = 5'b00000,
    stReady = 5'b00001,
    stExec = 5'b00010,
    stRecvHdr0 = 5'b01000,
    stRecvHdr1 = 5'b01001,
    stRecvHdr2 = 5'b01010,
    stRecvHdr3 = 5'b01011,
    stRecvHdr4 = 5'b01100,
    stRecvHdr5 = 5'b01101,
    stRecv = 5'b01110,
    stRecvLast = 5'b01111,
    stCplHdr0 = 5'b10000,
    stCplHdr1 = 5'b10001,
    stCplHdr2 = 5'b10010,
    stCplHdr3 = 5'b10011,
    stCplHdr4 = 5'b10100,
    stCplHdr5 = 5'b10101,
    stCpl = 5'b10110,
    stCplLast = 5'b10111
  } cmdState_t;

  typedef struct packed {
    logic [15:0] addr; // Locality in the top nibble
    byte_t wrData;
  } busReq_t;

  typedef struct packed {
    locality_t locality;
    regOffset_t offset;
    byte_t wrData;
  } tisAccess_t;

  typedef struct packed {
    ramAddr_t addr;
    byte_t wrData;
    logic wr; // Read whenever low
  } ramPort_t;

endpackage

`default_nettype wire

// ==== hdl/localityArbiter.sv ====
/* Locality arbiter
   TPM_ACCESS register, active locality and request/seize bookkeeping */
`default_nettype none
`include "tisConsts.svh"

module localityArbiter (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               rdStb_i,
  input  logic               wrStb_i,
  input  tisPkg::tisAccess_t access_i,
  output logic               accessMatch_o,
  output tisPkg::byte_t      rdData_o,
  output logic               rdHit_o,
  output logic               locChange_o,
  output logic               locAbort_o
);

  tisPkg::locality_t activeLoc;
  tisPkg::locality_t nextLoc; // Highest requester
  tisPkg::localityMask_t requestUse;
  tisPkg::localityMask_t beenSeized;
  tisPkg::localityMask_t ownBit;
  tisPkg::localityMask_t activeBit;
  tisPkg::localityMask_t nextBit;
  tisPkg::byte_t wd;
  logic accHit;
  logic noneActive;

  assign wd = access_i.wrData;
  assign ownBit = tisPkg::localityMask_t'(1) << access_i.locality;
  assign activeBit = tisPkg::localityMask_t'(1) << activeLoc; // Zero when none
  assign nextBit = tisPkg::localityMask_t'(1) << nextLoc;
  assign noneActive = activeLoc == `TIS_LOCALITY_NONE;
  assign accessMatch_o = access_i.locality == activeLoc;
  assign accHit = access_i.offset == `TIS_REG_ACCESS;
  assign rdHit_o = rdStb_i & accHit;

  // Valid, active, seized, pending request, own request, establishment
  assign rdData_o = {1'b1, 1'b0, accessMatch_o, |(beenSeized & ownBit), 1'b0,
                     |(requestUse & ~ownBit), |(requestUse & ownBit), 1'b1};

  always_comb begin
    nextLoc = `TIS_LOCALITY_NONE;
    for (int i = 0; i < `TIS_NUM_LOCALITIES; i++) begin
      if (requestUse[i]) nextLoc = tisPkg::locality_t'(i);
    end
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      activeLoc <= `TIS_LOCALITY_NONE;
      requestUse <= '0;
      beenSeized <= '0;
      locChange_o <= 1'b0;
      locAbort_o <= 1'b0;
    end else begin
      locChange_o <= 1'b0;
      locAbort_o <= 1'b0;
      // Only the lowest set field of a write acts
      if (wrStb_i && accHit) begin
        if (wd[`TIS_ACC_REQUEST_USE]) begin
          if (noneActive) activeLoc <= access_i.locality;
          else if (!accessMatch_o) requestUse <= requestUse | ownBit;
        end else if (wd[`TIS_ACC_SEIZE]) begin
          if (noneActive) begin
            activeLoc <= access_i.locality;
          end else if (access_i.locality > activeLoc) begin
            activeLoc <= access_i.locality;
            requestUse <= requestUse & ~ownBit;
            beenSeized <= beenSeized | activeBit;
            locChange_o <= |(requestUse & ownBit);
            locAbort_o <= 1'b1; // Preempted command dies
          end
        end else if (wd[`TIS_ACC_BEEN_SEIZED]) begin
          beenSeized <= beenSeized & ~ownBit;
        end else if (wd[`TIS_ACC_ACTIVE]) begin
          if (accessMatch_o) begin
            // Relinquish hands over to the highest requester
            activeLoc <= nextLoc;
            requestUse <= requestUse & ~nextBit;
            locChange_o <= nextLoc != `TIS_LOCALITY_NONE;
            locAbort_o <= 1'b1;
          end else begin
            requestUse <= requestUse & ~ownBit; // Withdraw own request
          end
        end
      end
    end
  end

  aActiveLocRange: assert property (@(posedge clk_i) disable iff (!rstN_i)
    (activeLoc < `TIS_NUM_LOCALITIES) || (activeLoc == `TIS_LOCALITY_NONE));

endmodule

`default_nettype wire

// ==== hdl/commandBuffer.sv ====
/* Command buffer
   Command FSM, length tracking, RAM pointer and the TPM_STS / DATA_FIFO registers */
`default_nettype none
`include "tisConsts.svh"

module commandBuffer (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               rdStb_i,
  input  logic               wrStb_i,
  input  tisPkg::tisAccess_t access_i,
  input  logic               accessMatch_i,
  input  logic               locAbort_i,
  input  logic               complete_i,
  input  tisPkg::byte_t      ramRdData_i,
  output tisPkg::byte_t      rdData_o,
  output logic               rdHit_o,
  output logic               dataAvailRise_o,
  output logic               exec_o,
  output logic               abort_o,
  output tisPkg::ramPort_t   ram_o
);

  tisPkg::cmdState_t state;
  tisPkg::fifoCount_t fifoLeft;
  tisPkg::regOffset_t regBase;
  tisPkg::byte_t wd;
  tisPkg::byte_t stepByte;
  logic [2:0] stepIdx;
  logic expectQ;
  logic dataAvail;
  logic cmdReady;
  logic stsHit;
  logic fifoHit;
  logic stsWr;
  logic cmdReadyWr;
  logic goWr;
  logic retryWr;
  logic cmdAbort;
  logic fifoWr;
  logic fifoRd;

  assign regBase = {access_i.offset[11:2], 2'b00};
  assign wd = access_i.wrData;
  assign stsHit = (regBase == `TIS_REG_STS) && accessMatch_i;
  assign fifoHit = (regBase == `TIS_REG_DATA_FIFO) && accessMatch_i;
  assign rdHit_o = rdStb_i & (stsHit | fifoHit);

  assign stsWr = wrStb_i & stsHit & (access_i.offset[1:0] == 2'd0);
  assign cmdReadyWr = stsWr & wd[`TIS_STS_CMD_READY];
  assign goWr = stsWr & wd[`TIS_STS_GO] & (state == tisPkg::stRecvLast);
  assign retryWr = stsWr & wd[`TIS_STS_RETRY] & (state[4:3] == 2'b10);
  assign cmdAbort = locAbort_i | (cmdReadyWr & (state != tisPkg::stIdle));

  assign fifoWr = wrStb_i & fifoHit & expectQ;
  assign fifoRd = rdStb_i & fifoHit & dataAvail;
  assign stepByte = fifoWr ? wd : ramRdData_i;
  assign stepIdx = state[2:0]; // Byte index within the transfer

  always_comb begin
    case (access_i.offset[1:0])
      2'd0: rdData_o = {1'b1, cmdReady, 1'b0, dataAvail, expectQ, 3'b000};
      2'd1: rdData_o = 8'h01; // Static burst count
      2'd2: rdData_o = 8'h00;
      default: rdData_o = 8'h04; // TPM 2.0 family
    endcase
    if (fifoHit) rdData_o = dataAvail ? ramRdData_i : 8'hFF;
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state <= tisPkg::stIdle;
      fifoLeft <= '0;
      expectQ <= 1'b0;
      dataAvail <= 1'b0;
      cmdReady <= 1'b0;
      exec_o <= 1'b0;
      abort_o <= 1'b0;
      dataAvailRise_o <= 1'b0;
      ram_o.addr <= '1;
      ram_o.wrData <= '0;
      ram_o.wr <= 1'b0;
    end else begin
      ram_o.wr <= 1'b0;
      dataAvailRise_o <= 1'b0;
      if (cmdAbort) begin
        state <= tisPkg::stIdle;
        fifoLeft <= '0;
        expectQ <= 1'b0;
        dataAvail <= 1'b0;
        cmdReady <= 1'b0;
        exec_o <= 1'b0;
        ram_o.addr <= '1; // Pointer is pre-incremented on the first write
        // Leaving cplLast is the normal end of a response
        if (locAbort_i || state != tisPkg::stCplLast) abort_o <= 1'b1;
      end else if (exec_o && complete_i) begin
        exec_o <= 1'b0;
        state <= tisPkg::stCplHdr0;
        dataAvail <= 1'b1;
        dataAvailRise_o <= 1'b1;
      end else if (cmdReadyWr) begin // From idle only
        state <= tisPkg::stReady;
        expectQ <= 1'b1;
        cmdReady <= 1'b1;
        abort_o <= 1'b0;
        ram_o.addr <= '1;
      end else if (goWr) begin
        state <= tisPkg::stExec;
        exec_o <= 1'b1;
        ram_o.addr <= '0;
      end else if (retryWr) begin
        state <= tisPkg::stCplHdr0;
        dataAvail <= 1'b1;
        dataAvailRise_o <= ~dataAvail;
        ram_o.addr <= '0;
      end else if (fifoWr || fifoRd) begin
        ram_o.addr <= ram_o.addr + 1'b1;
        ram_o.wr <= fifoWr;
        if (fifoWr) ram_o.wrData <= wd;
        if (state == tisPkg::stReady) begin
          state <= tisPkg::stRecvHdr1; // First byte counts as header byte 0
          cmdReady <= 1'b0;
        end else begin
          // Header bytes 2..5 carry the big-endian length
          case (stepIdx)
            3'd2, 3'd3, 3'd4: fifoLeft[8*(5-stepIdx) +: 8] <= stepByte;
            3'd5: fifoLeft <= {fifoLeft[31:8], stepByte} - (`TIS_CMD_HDR_LEN + 1);
            3'd6: fifoLeft <= fifoLeft - 1'b1;
            default: ;
          endcase
          if (stepIdx != 3'd6 || fifoLeft == '0) begin
            state <= tisPkg::cmdState_t'(state + 1'b1);
          end
          if (stepIdx == 3'd6 && fifoLeft == '0) begin
            expectQ <= 1'b0;   // End of command
            dataAvail <= 1'b0; // End of response
          end
        end
      end
    end
  end

  // Expect set only in the reception states that still take bytes
  aRamWrExpect: assert property (@(posedge clk_i) disable iff (!rstN_i)
    ram_o.wr |-> $past(expectQ) && ($past(state) == tisPkg::stReady ||
                 ($past(state[4:3]) == 2'b01 && $past(state) != tisPkg::stRecvLast)));

endmodule

`default_nettype wire

// ==== hdl/interruptCtrl.sv ====
/* Interrupt controller
   INT_ENABLE, INT_STATUS and INT_VECTOR registers with a level interrupt */
`default_nettype none
`include "tisConsts.svh"

module interruptCtrl (
  input  logic               clk_i,
  input  logic               rstN_i,
  input  logic               rdStb_i,
  input  logic               wrStb_i,
  input  tisPkg::tisAccess_t access_i,
  input  logic               accessMatch_i,
  input  logic               locChange_i,
  input  logic               dataAvailRise_i,
  output tisPkg::byte_t      rdData_o,
  output logic               rdHit_o,
  output tisPkg::locality_t  irqNum_o,
  output logic               interrupt_o
);

  tisPkg::regOffset_t regBase;
  tisPkg::byte_t wd;
  logic [1:0] byteSel;
  logic hit;
  logic armed;
  logic globalEn;
  logic dataAvailEn;
  logic locChangeEn;
  logic dataAvailSt;
  logic locChangeSt;

  assign regBase = {access_i.offset[11:2], 2'b00};
  assign byteSel = access_i.offset[1:0];
  assign wd = access_i.wrData;
  assign armed = globalEn & |irqNum_o; // No vector means no interrupt
  assign rdHit_o = rdStb_i & hit;

  always_comb begin
    rdData_o = 8'h00;
    hit = 1'b1;
    case (regBase)
      `TIS_REG_INT_ENABLE: begin
        if (byteSel == 2'd0) begin
          rdData_o[4:3] = 2'b01; // Low level polarity
          rdData_o[`TIS_INT_LOC_CHANGE] = locChangeEn;
          rdData_o[`TIS_INT_DATA_AVAIL] = dataAvailEn;
        end else if (byteSel == 2'd3) begin
          rdData_o[`TIS_INT_GLOBAL] = globalEn;
        end
      end
      `TIS_REG_INT_VECTOR: if (byteSel == 2'd0) rdData_o = {4'h0, irqNum_o};
      `TIS_REG_INT_STATUS: begin
        if (byteSel == 2'd0) begin
          rdData_o[`TIS_INT_LOC_CHANGE] = locChangeSt;
          rdData_o[`TIS_INT_DATA_AVAIL] = dataAvailSt;
        end
      end
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      globalEn <= 1'b0;
      dataAvailEn <= 1'b0;
      locChangeEn <= 1'b0;
      dataAvailSt <= 1'b0;
      locChangeSt <= 1'b0;
      irqNum_o <= '0;
      interrupt_o <= 1'b0;
    end else begin
      if (wrStb_i && accessMatch_i) begin
        case (regBase)
          `TIS_REG_INT_ENABLE: begin
            if (byteSel == 2'd0) begin
              dataAvailEn <= wd[`TIS_INT_DATA_AVAIL];
              locChangeEn <= wd[`TIS_INT_LOC_CHANGE];
            end else if (byteSel == 2'd3) begin
              globalEn <= wd[`TIS_INT_GLOBAL];
            end
          end
          `TIS_REG_INT_VECTOR: if (byteSel == 2'd0) irqNum_o <= wd[3:0];
          `TIS_REG_INT_STATUS: begin
            if (byteSel == 2'd0 && wd[`TIS_INT_DATA_AVAIL]) dataAvailSt <= 1'b0;
            if (byteSel == 2'd0 && wd[`TIS_INT_LOC_CHANGE]) locChangeSt <= 1'b0;
          end
          default: ;
        endcase
      end
      // A new event beats a clear in the same cycle
      if (armed && dataAvailEn && dataAvailRise_i) dataAvailSt <= 1'b1;
      if (armed && locChangeEn && locChange_i) locChangeSt <= 1'b1;
      interrupt_o <= armed & (dataAvailSt | locChangeSt);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tisRegs.sv ====
/* TPM TIS register file top
   Host byte handshake, access strobes, identity registers and read merge */
`default_nettype none
`include "tisConsts.svh"

module tisRegs (
  input  logic              clk_i,
  input  logic              rstN_i,
  input  tisPkg::busReq_t   hostReq_i,
  input  logic              dataReq_i,
  input  logic              dataWr_i,
  input  logic              complete_i,
  input  tisPkg::byte_t     ramRdData_i,
  output logic              dataRd_o,
  output logic              wrDone_o,
  output tisPkg::byte_t     data_o,
  output tisPkg::locality_t irqNum_o,
  output logic              interrupt_o,
  output logic              exec_o,
  output logic              abort_o,
  output tisPkg::ramPort_t  ram_o
);

  tisPkg::tisAccess_t access;
  tisPkg::regOffset_t regBase;
  tisPkg::byte_t rdByte;
  tisPkg::byte_t arbByte;
  tisPkg::byte_t cmdByte;
  tisPkg::byte_t irqByte;
  logic [31:0] idWord;
  logic idHit;
  logic arbHit;
  logic cmdHit;
  logic irqHit;
  logic rdPend; // Read accepted, answered next edge
  logic wrPend;
  logic busy;
  logic locValid;
  logic rdStb;
  logic wrStb;
  logic accessMatch;
  logic locChange;
  logic locAbort;
  logic dataAvailRise;

  // Host holds the address stable for the whole access
  assign access.locality = hostReq_i.addr[15:12];
  assign access.offset = hostReq_i.addr[11:0];
  assign access.wrData = hostReq_i.wrData;
  assign regBase = {access.offset[11:2], 2'b00};
  assign locValid = access.locality < `TIS_NUM_LOCALITIES;
  assign busy = rdPend | wrPend | dataRd_o | wrDone_o;
  assign rdStb = rdPend & locValid;
  assign wrStb = wrPend & locValid;

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rdPend <= 1'b0;
      wrPend <= 1'b0;
      dataRd_o <= 1'b0;
      wrDone_o <= 1'b0;
    end else begin
      rdPend <= dataReq_i & ~busy;
      wrPend <= dataWr_i & ~dataReq_i & ~busy; // Reads go first
      if (rdPend) dataRd_o <= 1'b1;
      else if (!dataReq_i) dataRd_o <= 1'b0;
      if (wrPend) wrDone_o <= 1'b1;
      else if (!dataWr_i) wrDone_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdPend) data_o <= rdByte;
  end

  always_comb begin
    idWord = 32'h0;
    idHit = locValid;
    case (regBase)
      `TIS_REG_DID_VID: idWord = `TIS_DID_VID;
      `TIS_REG_RID: idWord = `TIS_RID;
      `TIS_REG_INTERFACE_ID: idWord = `TIS_INTERFACE_ID;
      `TIS_REG_INTF_CAP: idWord = `TIS_INTF_CAP;
      default: idHit = 1'b0;
    endcase
    if (arbHit) rdByte = arbByte;
    else if (cmdHit) rdByte = cmdByte;
    else if (irqHit) rdByte = irqByte;
    else if (idHit) rdByte = idWord[8*access.offset[1:0] +: 8];
    else rdByte = 8'hFF; // Unmapped or out-of-range locality
  end

  localityArbiter i_arbiter (
    .clk_i(clk_i),
    .rstN_i(rstN_i),
    .rdStb_i(rdStb),
    .wrStb_i(wrStb),
    .access_i(access),
    .accessMatch_o(accessMatch),
    .rdData_o(arbByte),
    .rdHit_o(arbHit),
    .locChange_o(locChange),
    .locAbort_o(locAbort)
  );

  commandBuffer i_cmdBuf (
    .clk_i(clk_i),
    .rstN_i(rstN_i),
    .rdStb_i(rdStb),
    .wrStb_i(wrStb),
    .access_i(access),
    .accessMatch_i(accessMatch),
    .locAbort_i(locAbort),
    .complete_i(complete_i),
    .ramRdData_i(ramRdData_i),
    .rdData_o(cmdByte),
    .rdHit_o(cmdHit),
    .dataAvailRise_o(dataAvailRise),
    .exec_o(exec_o),
    .abort_o(abort_o),
    .ram_o(ram_o)
  );

  interruptCtrl i_irq (
    .clk_i(clk_i),
    .rstN_i(rstN_i),
    .rdStb_i(rdStb),
    .wrStb_i(wrStb),
    .access_i(access),
    .accessMatch_i(accessMatch),
    .locChange_i(locChange),
    .dataAvailRise_i(dataAvailRise),
    .rdData_o(irqByte),
    .rdHit_o(irqHit),
    .irqNum_o(irqNum_o),
    .interrupt_o(interrupt_o)
  );

  aOneDone: assert property (@(posedge clk_i) disable iff (!rstN_i)
    !(dataRd_o && wrDone_o));

endmodule

`default_nettype wire

// ==== verif/tisTbTests.svh ====
/* TIS testbench tests
   Reference models, compare tasks, host bus tasks and the six tests */

  localparam int SigExec = 0;
  localparam int SigIrq = 1;
  localparam int WaitLimit = 50;

  logic [31:0] rngState = 32'hcb32_34cc;
  string curTest;
  int testErrs = 0;

  // What the host should see, updated by the tests from the TIS rules
  tisPkg::locality_t modelActive = `TIS_LOCALITY_NONE;
  tisPkg::localityMask_t modelRequest = '0;
  tisPkg::localityMask_t modelSeized = '0;
  logic modelCmdReady = 1'b0;
  logic modelDataAvail = 1'b0;
  logic modelExpect = 1'b0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic tisPkg::byte_t randByte();
    rngState = xorshift32(rngState);
    return rngState[7:0];
  endfunction

  function automatic tisPkg::byte_t fillByte(input tisPkg::ramAddr_t a);
    return a[7:0] ^ {5'b0, a[10:8]} ^ 8'hA5;
  endfunction

  // Frame length, most significant byte at header byte 2
  function automatic tisPkg::byte_t lenByte(input int len, input int idx);
    logic [31:0] l;
    l = len;
    return l[8 * (5 - idx) +: 8];
  endfunction

  function automatic tisPkg::byte_t expAccess(input tisPkg::locality_t loc);
    tisPkg::localityMask_t own;
    own = tisPkg::localityMask_t'(1) << loc;
    return {1'b1, 1'b0, loc == modelActive, |(modelSeized & own), 1'b0,
            |(modelRequest & ~own), |(modelRequest & own), 1'b1};
  endfunction

  function automatic tisPkg::byte_t expSts(input tisPkg::locality_t loc, input int idx);
    if (loc != modelActive) return 8'hFF; // Only the active locality sees STS
    case (idx)
      0: return {1'b1, modelCmdReady, 1'b0, modelDataAvail, modelExpect, 3'b000};
      1: return 8'h01;
      2: return 8'h00;
      default: return 8'h04;
    endcase
  endfunction

  task automatic checkByte(input string what, input tisPkg::byte_t exp,
                           input tisPkg::byte_t act);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      testErrs++;
      $display("FAILED %s, %s: expected %h, actual %h", curTest, what, exp, act);
    end
  endtask

  task automatic checkBit(input string what, input logic exp, input logic act);
    checkCount++;
    if (act !== exp) begin
      errCount++;
      testErrs++;
      $display("FAILED %s, %s: expected %b, actual %b", curTest, what, exp, act);
    end
  endtask

  task automatic waitLevel(input string what, input int sel, input logic level);
    int n;
    logic now;
    n = 0;
    now = (sel == SigExec) ? exec : interrupt;
    while (now !== level && n < WaitLimit) begin
      @(posedge clk);
      #DriveDelay;
      n++;
      now = (sel == SigExec) ? exec : interrupt;
    end
    checkCount++;
    if (now !== level) begin
      errCount++;
      testErrs++;
      $display("ERROR %s: %s stayed at %b for %0d cycles", curTest, what, now, WaitLimit);
    end
  endtask

  task automatic busRead(input tisPkg::locality_t loc, input tisPkg::regOffset_t off,
                         output tisPkg::byte_t data);
    hostReq.addr = {loc, off};
    hostReq.wrData = 8'h00;
    dataReq = 1'b1;
    do begin
      @(posedge clk);
      #DriveDelay;
    end while (!dataRd);
    data = dataOut;
    dataReq = 1'b0;
    do begin
      @(posedge clk);
      #DriveDelay;
    end while (dataRd);
  endtask

  task automatic busWrite(input tisPkg::locality_t loc, input tisPkg::regOffset_t off,
                          input tisPkg::byte_t data);
    hostReq.addr = {loc, off};
    hostReq.wrData = data;
    dataWr = 1'b1;
    do begin
      @(posedge clk);
      #DriveDelay;
    end while (!wrDone);
    dataWr = 1'b0;
    do begin
      @(posedge clk);
      #DriveDelay;
    end while (wrDone);
  endtask

  task automatic readCheck(input string what, input tisPkg::locality_t loc,
                           input tisPkg::regOffset_t off, input tisPkg::byte_t exp);
    tisPkg::byte_t data;
    busRead(loc, off, data);
    checkByte(what, exp, data);
  endtask

  task automatic sendCommand(input tisPkg::locality_t loc, input int count);
    for (int i = 0; i < count; i++) begin
      busWrite(loc, `TIS_REG_DATA_FIFO, cmdBuf[i]);
      modelCmdReady = 1'b0;
    end
    if (count >= cmdLen) modelExpect = 1'b0; // Whole length taken
  endtask

  task automatic readResponse(input tisPkg::locality_t loc);
    tisPkg::byte_t data;
    for (int i = 0; i < respLen; i++) begin
      busRead(loc, `TIS_REG_DATA_FIFO, data);
      checkByte($sformatf("response byte %0d", i), respBuf[i], data);
    end
    modelDataAvail = 1'b0;
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrs = 0;
  endtask

  task automatic endTest();
    testsRun++;
    if (testErrs == 0) $display("test %s: ok", curTest);
    else $display("test %s: %0d errors", curTest, testErrs);
  endtask

  task automatic testIdentity();
    logic [31:0] didVid;
    startTest("identity");
    didVid = `TIS_DID_VID;
    for (int i = 0; i < 4; i++) begin
      readCheck($sformatf("DID_VID byte %0d", i), 4'd0,
                `TIS_REG_DID_VID + tisPkg::regOffset_t'(i), didVid[8*i +: 8]);
    end
    readCheck("INTERFACE_ID byte 0", 4'd0, `TIS_REG_INTERFACE_ID, 8'h00);
    readCheck("INTERFACE_ID byte 1", 4'd0, `TIS_REG_INTERFACE_ID + 12'd1, 8'h21);
    readCheck("INTF_CAPABILITY byte 0", 4'd1, `TIS_REG_INTF_CAP, 8'h15);
    readCheck("INTF_CAPABILITY byte 1", 4'd1, `TIS_REG_INTF_CAP + 12'd1, 8'h01);
    readCheck("INTF_CAPABILITY byte 2", 4'd1, `TIS_REG_INTF_CAP + 12'd2, 8'h00);
    readCheck("INTF_CAPABILITY byte 3", 4'd1, `TIS_REG_INTF_CAP + 12'd3, 8'h30);
    readCheck("RID", 4'd3, `TIS_REG_RID, 8'h00);
    readCheck("locality 5 DID_VID", 4'd5, `TIS_REG_DID_VID, 8'hFF);
    readCheck("ACCESS after reset", 4'd0, `TIS_REG_ACCESS, expAccess(4'd0));
    endTest();
  endtask

  task automatic testLocalities();
    startTest("localities");
    busWrite(4'd0, `TIS_REG_ACCESS, 8'h02);
    modelActive = 4'd0; // Nobody active, so the request is granted at once
    readCheck("locality 0 ACCESS", 4'd0, `TIS_REG_ACCESS, expAccess(4'd0));
    busWrite(4'd2, `TIS_REG_ACCESS, 8'h02);
    modelRequest[2] = 1'b1;
    readCheck("pendingRequest", 4'd0, `TIS_REG_ACCESS, expAccess(4'd0));
    readCheck("locality 2 ACCESS", 4'd2, `TIS_REG_ACCESS, expAccess(4'd2));
    busWrite(4'd0, `TIS_REG_INT_ENABLE, 8'h04);
    busWrite(4'd0, `TIS_REG_INT_ENABLE + 12'd3, 8'h80);
    busWrite(4'd0, `TIS_REG_INT_VECTOR, 8'h03);
    readCheck("INT_VECTOR", 4'd0, `TIS_REG_INT_VECTOR, 8'h03);
    checkBit("interrupt_o before handoff", 1'b0, interrupt);
    busWrite(4'd0, `TIS_REG_ACCESS, 8'h20);
    modelActive = 4'd2;
    modelRequest = '0;
    waitLevel("interrupt_o after handoff", SigIrq, 1'b1);
    readCheck("locality 2 ACCESS after handoff", 4'd2, `TIS_REG_ACCESS, expAccess(4'd2));
    readCheck("localityChange status", 4'd2, `TIS_REG_INT_STATUS, 8'h04);
    busWrite(4'd2, `TIS_REG_INT_STATUS, 8'h04);
    waitLevel("interrupt_o after clear", SigIrq, 1'b0);
    endTest();
  endtask

  task automatic testCommand();
    tisPkg::byte_t b;
    startTest("command");
    busWrite(4'd2, `TIS_REG_INT_ENABLE, 8'h05); // dataAvail and localityChange
    busWrite(4'd2, `TIS_REG_STS, 8'h40);
    modelCmdReady = 1'b1;
    modelExpect = 1'b1;
    checkBit("abort_o after commandReady", 1'b0, abort);
    for (int i = 0; i < 4; i++) begin
      readCheck($sformatf("STS byte %0d", i), 4'd2,
                `TIS_REG_STS + tisPkg::regOffset_t'(i), expSts(4'd2, i));
    end
    b = randByte();
    cmdLen = 10 + int'(b[3:0]);
    for (int i = 0; i < cmdLen; i++) begin
      cmdBuf[i] = (i >= 2 && i <= 5) ? lenByte(cmdLen, i) : randByte();
    end
    sendCommand(4'd2, cmdLen);
    readCheck("STS after last byte", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    for (int i = 0; i < cmdLen; i++) begin
      checkByte($sformatf("RAM byte %0d", i), cmdBuf[i], ram[i]);
    end
    busWrite(4'd2, `TIS_REG_DATA_FIFO, 8'hEE);
    busWrite(4'd2, `TIS_REG_DATA_FIFO, 8'h11);
    checkByte("RAM past the command", fillByte(tisPkg::ramAddr_t'(cmdLen)), ram[cmdLen]);
    checkByte("RAM two past the command", fillByte(tisPkg::ramAddr_t'(cmdLen + 1)),
              ram[cmdLen + 1]);
    // Response the MCU hands back for this command
    b = randByte();
    respLen = 8 + int'(b[3:0]);
    for (int i = 0; i < respLen; i++) begin
      respBuf[i] = (i >= 2 && i <= 5) ? lenByte(respLen, i) : randByte();
    end
    busWrite(4'd2, `TIS_REG_STS, 8'h20);
    waitLevel("exec_o after tpmGo", SigExec, 1'b1);
    endTest();
  endtask

  task automatic testResponse();
    startTest("response");
    waitLevel("exec_o after complete", SigExec, 1'b0);
    modelDataAvail = 1'b1;
    readCheck("STS with response", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    waitLevel("dataAvail interrupt", SigIrq, 1'b1);
    readCheck("dataAvail status", 4'd2, `TIS_REG_INT_STATUS, 8'h01);
    readResponse(4'd2);
    readCheck("STS after response", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    busWrite(4'd2, `TIS_REG_INT_STATUS, 8'h01);
    waitLevel("interrupt_o after clear", SigIrq, 1'b0);
    busWrite(4'd2, `TIS_REG_STS, 8'h02);
    modelDataAvail = 1'b1;
    readCheck("STS after responseRetry", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    readResponse(4'd2);
    readCheck("STS after replay", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    endTest();
  endtask

  task automatic testAbort();
    startTest("abort");
    busWrite(4'd2, `TIS_REG_STS, 8'h40); // Normal end of the response
    checkBit("abort_o after response end", 1'b0, abort);
    readCheck("STS back in idle", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    busWrite(4'd2, `TIS_REG_STS, 8'h40);
    modelCmdReady = 1'b1;
    modelExpect = 1'b1;
    sendCommand(4'd2, 3);
    readCheck("STS during reception", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    busWrite(4'd2, `TIS_REG_STS, 8'h40);
    modelExpect = 1'b0;
    checkBit("abort_o after commandReady in reception", 1'b1, abort);
    readCheck("STS after abort", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    busWrite(4'd2, `TIS_REG_STS, 8'h40);
    modelCmdReady = 1'b1;
    modelExpect = 1'b1;
    checkBit("abort_o after new commandReady", 1'b0, abort);
    sendCommand(4'd2, cmdLen);
    mcuHold = 1'b1;
    busWrite(4'd2, `TIS_REG_STS, 8'h20);
    waitLevel("exec_o before seize", SigExec, 1'b1);
    busWrite(4'd4, `TIS_REG_ACCESS, 8'h08);
    modelActive = 4'd4;
    modelSeized[2] = 1'b1;
    checkBit("abort_o after seize", 1'b1, abort);
    checkBit("exec_o after seize", 1'b0, exec);
    readCheck("locality 2 ACCESS after seize", 4'd2, `TIS_REG_ACCESS, expAccess(4'd2));
    readCheck("locality 4 ACCESS after seize", 4'd4, `TIS_REG_ACCESS, expAccess(4'd4));
    readCheck("STS after seize", 4'd4, `TIS_REG_STS, expSts(4'd4, 0));
    mcuHold = 1'b0;
    endTest();
  endtask

  task automatic testIsolation();
    startTest("isolation");
    busWrite(4'd2, `TIS_REG_INT_VECTOR, 8'h07);
    readCheck("INT_VECTOR after foreign write", 4'd4, `TIS_REG_INT_VECTOR, 8'h03);
    checkByte("irqNum_o after foreign write", 8'h03, {4'h0, irqNum});
    busWrite(4'd2, `TIS_REG_STS, 8'h40);
    readCheck("STS after foreign write", 4'd4, `TIS_REG_STS, expSts(4'd4, 0));
    readCheck("STS from inactive locality", 4'd2, `TIS_REG_STS, expSts(4'd2, 0));
    endTest();
  endtask

// ==== verif/tisRegsTb.sv ====
/* TIS register file testbench
   Clock, reset, DUT, RAM and MCU models, timeout and the closing summary */
`default_nettype none
`include "tisConsts.svh"

module tisRegsTb;

  localparam int RamDepth = 1 << `TIS_RAM_ADDR_W;
  localparam int ClkPeriod = 100;
  localparam int DriveDelay = 10; // Inputs change this long after the rising edge
  localparam int McuLatency = 3;
  // About 250 host accesses of up to 6 cycles each, plus MCU waits, with wide margin
  localparam int TimeoutCycles = 20000;

  logic clk;
  logic rstN;
  tisPkg::busReq_t hostReq;
  logic dataReq;
  logic dataWr;
  logic complete;
  tisPkg::byte_t ramRdData;
  logic dataRd;
  logic wrDone;
  tisPkg::byte_t dataOut;
  tisPkg::locality_t irqNum;
  logic interrupt;
  logic exec;
  logic abort;
  tisPkg::ramPort_t ramPort;

  tisPkg::byte_t ram [RamDepth];
  tisPkg::byte_t cmdBuf [64];
  tisPkg::byte_t respBuf [64];
  int cmdLen = 0;
  int respLen = 0;
  logic mcuLoad;
  logic mcuHold; // Keeps the MCU from completing
  int cycles = 0;
  int errCount = 0;
  int checkCount = 0;
  int testsRun = 0;

  `include "tisTbTests.svh"

  tisRegs i_dut (
    .clk_i(clk),
    .rstN_i(rstN),
    .hostReq_i(hostReq),
    .dataReq_i(dataReq),
    .dataWr_i(dataWr),
    .complete_i(complete),
    .ramRdData_i(ramRdData),
    .dataRd_o(dataRd),
    .wrDone_o(wrDone),
    .data_o(dataOut),
    .irqNum_o(irqNum),
    .interrupt_o(interrupt),
    .exec_o(exec),
    .abort_o(abort),
    .ram_o(ramPort)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  assign ramRdData = ram[ramPort.addr]; // Asynchronous read

  // RAM write port, shared by the DUT and the MCU response load
  always @(posedge clk) begin
    if (!rstN) begin
      for (int a = 0; a < RamDepth; a++) ram[a] <= fillByte(tisPkg::ramAddr_t'(a));
    end else begin
      if (ramPort.wr) ram[ramPort.addr] <= ramPort.wrData;
      if (mcuLoad) begin
        for (int i = 0; i < respLen; i++) ram[i] <= respBuf[i];
      end
    end
  end

  // MCU model
  initial begin
    complete = 1'b0;
    mcuLoad = 1'b0;
    forever begin
      @(posedge clk);
      #DriveDelay;
      if (exec && !mcuHold) begin
        repeat (McuLatency) @(posedge clk);
        #DriveDelay;
        mcuLoad = 1'b1; // Response goes in before complete
        @(posedge clk);
        #DriveDelay;
        mcuLoad = 1'b0;
        complete = 1'b1;
        @(posedge clk);
        #DriveDelay;
        complete = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: the DUT did not finish the tests within %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    hostReq = '0;
    dataReq = 1'b0;
    dataWr = 1'b0;
    mcuHold = 1'b0;
    repeat (4) @(posedge clk);
    #DriveDelay;
    rstN = 1'b1;
    testIdentity();
    testLocalities();
    testCommand();
    testResponse();
    testAbort();
    testIsolation();
    $display("tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errCount);
    if (errCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tisRegs.f ====
+incdir+hdl
+incdir+verif
hdl/tisPkg.sv
hdl/localityArbiter.sv
hdl/commandBuffer.sv
hdl/interruptCtrl.sv
hdl/tisRegs.sv
verif/tisRegsTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the TIS register file testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tisRegs.f --top-module tisRegsTb -o tisRegsSim &&
  ./obj_dir/tisRegsSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -sqx "PASS: all tests" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
